// File: list.f
+incdir+testbench
logic/isaPkg.sv
logic/microPkg.sv
logic/stepSequencer.sv
logic/branchDecoder.sv
logic/aluDecoder.sv
logic/decodeSlice.sv
testbench/decodeSliceTb.sv

// File: logic/aluDecoder.sv
// Micro-op decoder for the accumulator ALU group.
`default_nettype none

module aluDecoder (
    input  wire                     aluEn,
    input  wire isaPkg::opcode_t    heldOp,
    input  wire microPkg::step_t    step,
    output logic                    memRead,
    output logic                    writeA,
    output logic                    writeFlags,
    output logic                    last,
    output isaPkg::aluOp_t          aluOp
);

    logic useImm;
    logic execute;
    isaPkg::aluOp_t decodedOp;

    assign useImm = heldOp[isaPkg::immBit];

    // An immediate operand takes one extra read step before the operation.
    assign execute = aluEn && (step == microPkg::step_t'(useImm));

    always_comb begin
        case (heldOp[isaPkg::aluMsb:isaPkg::aluLsb])
            3'd0: decodedOp = isaPkg::aluAdd;
            3'd1: decodedOp = isaPkg::aluAdc;
            3'd2: decodedOp = isaPkg::aluSub;
            3'd3: decodedOp = isaPkg::aluSbc;
            3'd4: decodedOp = isaPkg::aluAnd;
            3'd5: decodedOp = isaPkg::aluOr;
            3'd6: decodedOp = isaPkg::aluXor;
            default: decodedOp = isaPkg::aluCp;
        endcase
    end

    assign memRead    = aluEn && useImm && (step == '0);
    assign aluOp      = execute ? decodedOp : isaPkg::aluNop;
    assign writeFlags = execute;
    assign writeA     = execute && (decodedOp != isaPkg::aluCp); // compare keeps A.
    assign last       = execute;

endmodule

`default_nettype wire

// File: logic/branchDecoder.sv
// Micro-op decoder for the conditional jump and conditional call groups.
`default_nettype none

module branchDecoder (
    input  wire                     jumpEn,
    input  wire                     callEn,
    input  wire isaPkg::opcode_t    heldOp,
    input  wire microPkg::flags_t   heldFlags,
    input  wire microPkg::step_t    step,
    output logic                    memRead,
    output logic                    memWrite,
    output logic                    spDec,
    output logic                    pcLoad,
    output logic                    last,
    output microPkg::wrSel_t        wrSel
);

    logic enabled;
    logic taken;
    isaPkg::cond_t cond;

    assign enabled = jumpEn || callEn;
    assign cond    = isaPkg::cond_t'(heldOp[isaPkg::condMsb:isaPkg::condLsb]);
    assign taken   = (heldFlags[cond] == heldOp[isaPkg::polarityBit]);

    always_comb begin
        memRead  = 1'b0;
        memWrite = 1'b0;
        spDec    = 1'b0;
        pcLoad   = 1'b0;
        last     = 1'b0;
        wrSel    = microPkg::wrNone;
        if (enabled) begin
            case (step)
                0: begin
                    memRead = 1'b1; // low byte of the target.
                end
                1: begin
                    memRead = 1'b1;
                    last    = !taken; // both target bytes are read even when not taken.
                end
                2: begin
                    if (jumpEn) begin
                        pcLoad = 1'b1;
                        last   = 1'b1;
                    end else begin
                        spDec    = 1'b1;
                        memWrite = 1'b1;
                        wrSel    = microPkg::wrPcHigh;
                    end
                end
                3: begin
                    if (callEn) begin
                        spDec    = 1'b1;
                        memWrite = 1'b1;
                        wrSel    = microPkg::wrPcLow;
                    end
                end
                4: begin
                    if (callEn) begin
                        pcLoad = 1'b1;
                        last   = 1'b1;
                    end
                end
                default: begin
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: logic/decodeSlice.sv
// Decode slice top level that runs the step sequencer and merges the group decoders by OR.
`default_nettype none

module decodeSlice (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     opValid,
    input  wire isaPkg::opcode_t    opcode,
    input  wire microPkg::flags_t   flags,
    input  wire                     creditReturn,
    output logic                    opReady,
    output logic                    uopValid,
    output logic                    uopLast,
    output logic                    memRead,
    output logic                    memWrite,
    output logic                    spDec,
    output logic                    pcLoad,
    output logic                    writeA,
    output logic                    writeFlags,
    output microPkg::wrSel_t        wrSel,
    output isaPkg::aluOp_t          aluOp
);

    isaPkg::opcode_t heldOp;
    microPkg::flags_t heldFlags;
    microPkg::step_t step;
    logic jumpEn;
    logic callEn;
    logic aluEn;
    logic issue;
    logic illegalLast;
    logic mergedLast;

    logic brMemRead;
    logic brMemWrite;
    logic brSpDec;
    logic brPcLoad;
    logic brLast;
    microPkg::wrSel_t brWrSel;

    logic aluMemRead;
    logic aluWriteA;
    logic aluWriteFlags;
    logic aluLast;
    isaPkg::aluOp_t aluDecOp;

    stepSequencer sequencer (
        .clk(clk),
        .rst(rst),
        .opValid(opValid),
        .opcode(opcode),
        .flags(flags),
        .creditReturn(creditReturn),
        .last(mergedLast),
        .opReady(opReady),
        .heldOp(heldOp),
        .heldFlags(heldFlags),
        .step(step),
        .jumpEn(jumpEn),
        .callEn(callEn),
        .aluEn(aluEn),
        .issue(issue),
        .illegalLast(illegalLast)
    );

    branchDecoder branch (
        .jumpEn(jumpEn),
        .callEn(callEn),
        .heldOp(heldOp),
        .heldFlags(heldFlags),
        .step(step),
        .memRead(brMemRead),
        .memWrite(brMemWrite),
        .spDec(brSpDec),
        .pcLoad(brPcLoad),
        .last(brLast),
        .wrSel(brWrSel)
    );

    aluDecoder alu (
        .aluEn(aluEn),
        .heldOp(heldOp),
        .step(step),
        .memRead(aluMemRead),
        .writeA(aluWriteA),
        .writeFlags(aluWriteFlags),
        .last(aluLast),
        .aluOp(aluDecOp)
    );

    // Idle decoders drive zeros, so a plain OR picks the active one.
    assign mergedLast = brLast | aluLast | illegalLast;

    assign uopValid   = issue;
    assign uopLast    = issue & mergedLast;
    assign memRead    = issue & (brMemRead | aluMemRead);
    assign memWrite   = issue & brMemWrite;
    assign spDec      = issue & brSpDec;
    assign pcLoad     = issue & brPcLoad;
    assign writeA     = issue & aluWriteA;
    assign writeFlags = issue & aluWriteFlags;
    assign wrSel      = issue ? brWrSel : microPkg::wrNone;
    assign aluOp      = issue ? aluDecOp : isaPkg::aluNop;

endmodule

`default_nettype wire

// File: logic/isaPkg.sv
// Instruction set definitions for the decode slice: opcode groups, ALU operations and fields.
`default_nettype none

package isaPkg;

    typedef logic [7:0] opcode_t;

    // Opcode groups taken from bits 7:6.
    typedef enum logic [1:0] {
        grpMisc = 2'b00,
        grpJump = 2'b01,
        grpCall = 2'b10,
        grpAlu  = 2'b11
    } group_t;

    typedef enum logic [3:0] {
        aluNop = 4'd0,
        aluAdd = 4'd1,
        aluAdc = 4'd2,
        aluSub = 4'd3,
        aluSbc = 4'd4,
        aluAnd = 4'd5,
        aluOr  = 4'd6,
        aluXor = 4'd7,
        aluCp  = 4'd8
    } aluOp_t;

    typedef enum logic [1:0] {
        condZ  = 2'b00, // the value doubles as the bit index into flags_t.
        condC  = 2'b01,
        condPv = 2'b10,
        condS  = 2'b11
    } cond_t;

    localparam int groupMsb    = 7;
    localparam int groupLsb    = 6;
    localparam int condMsb     = 5;
    localparam int condLsb     = 4;
    localparam int immBit      = 4; // shares its position with condLsb in the ALU group.
    localparam int halfBit     = 3; // only opcodes with this bit set are decoded here.
    localparam int polarityBit = 2;
    localparam int aluMsb      = 2;
    localparam int aluLsb      = 0;

endpackage

`default_nettype wire

// File: logic/microPkg.sv
// Micro-op machinery definitions: step counter, queue credits, write-data selects and flags.
`default_nettype none

package microPkg;

    localparam int stepWidth = 3;

    typedef logic [stepWidth-1:0] step_t;

    typedef logic [2:0] credit_t;

    // Entries in the micro-op queue downstream.
    localparam credit_t creditInit = 3'd4;

    typedef enum logic [1:0] {
        wrNone   = 2'b00,
        wrPcHigh = 2'b01,
        wrPcLow  = 2'b10
    } wrSel_t;

    // Bit 0 is Z, bit 1 is C, bit 2 is PV and bit 3 is S.
    typedef logic [3:0] flags_t;

endpackage

`default_nettype wire

// File: logic/stepSequencer.sv
// Step sequencer that holds one opcode, walks its micro-op steps and keeps the queue credits.
`default_nettype none

module stepSequencer (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     opValid,
    input  wire isaPkg::opcode_t    opcode,
    input  wire microPkg::flags_t   flags,
    input  wire                     creditReturn,
    input  wire                     last,
    output logic                    opReady,
    output isaPkg::opcode_t         heldOp,
    output microPkg::flags_t        heldFlags,
    output microPkg::step_t         step,
    output logic                    jumpEn,
    output logic                    callEn,
    output logic                    aluEn,
    output logic                    issue,
    output logic                    illegalLast
);

    logic busy;
    logic accept;
    logic done;
    logic halfSet;
    logic illegal;
    isaPkg::group_t group;
    microPkg::credit_t credits;

    assign group   = isaPkg::group_t'(heldOp[isaPkg::groupMsb:isaPkg::groupLsb]);
    assign halfSet = heldOp[isaPkg::halfBit];

    assign jumpEn  = busy && halfSet && (group == isaPkg::grpJump);
    assign callEn  = busy && halfSet && (group == isaPkg::grpCall);
    assign aluEn   = busy && halfSet && (group == isaPkg::grpAlu);
    assign illegal = busy && (!halfSet || (group == isaPkg::grpMisc));

    // An illegal opcode is a single no-operation step, so it ends right away.
    assign illegalLast = illegal;

    assign issue   = busy && (credits != '0);
    assign done    = issue && last;
    assign opReady = !busy || done; // a new opcode may follow the last micro-op directly.
    assign accept  = opValid && opReady;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            step <= '0;
        end else if (accept) begin
            busy <= 1'b1;
            step <= '0;
        end else if (done) begin
            busy <= 1'b0;
            step <= '0;
        end else if (issue) begin
            step <= microPkg::step_t'(step + 1'b1);
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            heldOp    <= opcode;
            heldFlags <= flags; // flags are frozen for the whole instruction.
        end
    end

    // One credit leaves per issued micro-op and one comes back per freed queue entry.
    always_ff @(posedge clk) begin
        if (rst) begin
            credits <= microPkg::creditInit;
        end else begin
            credits <= microPkg::credit_t'(credits + creditReturn - issue);
        end
    end

    creditBound: assert property (@(posedge clk) disable iff (rst)
        credits <= microPkg::creditInit);

    // The longest instruction, a taken call, ends at step 4.
    stepBound: assert property (@(posedge clk) disable iff (rst)
        issue |-> (step <= microPkg::step_t'(4)));

endmodule

`default_nettype wire

// File: testbench/decodeRef.svh
// Reference model that expands one opcode and its flags into the expected micro-op list.
`ifndef DECODE_REF_SVH
`define DECODE_REF_SVH

// Bit positions inside one expected micro-op word.
localparam int posLast       = 12;
localparam int posMemRead    = 11;
localparam int posMemWrite   = 10;
localparam int posSpDec      = 9;
localparam int posPcLoad     = 8;
localparam int posWriteA     = 7;
localparam int posWriteFlags = 6;

typedef logic [12:0] uop_t; // wrSel sits in 5:4 and aluOp in 3:0.
typedef uop_t uopList_t[$];

function automatic uop_t makeUop(input logic lastBit, input logic rd, input logic wr,
                                 input logic sp, input logic pc, input logic wa,
                                 input logic wf, input microPkg::wrSel_t ws,
                                 input isaPkg::aluOp_t op);
    uop_t u;
    u = {lastBit, rd, wr, sp, pc, wa, wf, ws, op};
    return u;
endfunction

function automatic uopList_t expandOp(input isaPkg::opcode_t op, input microPkg::flags_t fl);
    uopList_t list;
    isaPkg::group_t grp;
    isaPkg::aluOp_t aop;
    logic flagVal;
    logic taken;
    list = {};
    grp = isaPkg::group_t'(op[isaPkg::groupMsb:isaPkg::groupLsb]);
    case (isaPkg::cond_t'(op[isaPkg::condMsb:isaPkg::condLsb]))
        isaPkg::condZ:  flagVal = fl[0];
        isaPkg::condC:  flagVal = fl[1];
        isaPkg::condPv: flagVal = fl[2];
        default:        flagVal = fl[3];
    endcase
    taken = (flagVal == op[isaPkg::polarityBit]); // polarity bit is the flag value that takes.
    case (op[2:0])
        3'd0: aop = isaPkg::aluAdd;
        3'd1: aop = isaPkg::aluAdc;
        3'd2: aop = isaPkg::aluSub;
        3'd3: aop = isaPkg::aluSbc;
        3'd4: aop = isaPkg::aluAnd;
        3'd5: aop = isaPkg::aluOr;
        3'd6: aop = isaPkg::aluXor;
        default: aop = isaPkg::aluCp;
    endcase
    if (!op[isaPkg::halfBit] || grp == isaPkg::grpMisc) begin
        list.push_back(makeUop(1, 0, 0, 0, 0, 0, 0, microPkg::wrNone, isaPkg::aluNop));
    end else if (grp == isaPkg::grpAlu) begin
        if (op[isaPkg::immBit]) begin
            list.push_back(makeUop(0, 1, 0, 0, 0, 0, 0, microPkg::wrNone, isaPkg::aluNop));
        end
        list.push_back(makeUop(1, 0, 0, 0, 0, aop != isaPkg::aluCp, 1, microPkg::wrNone, aop));
    end else begin
        list.push_back(makeUop(0, 1, 0, 0, 0, 0, 0, microPkg::wrNone, isaPkg::aluNop));
        list.push_back(makeUop(!taken, 1, 0, 0, 0, 0, 0, microPkg::wrNone, isaPkg::aluNop));
        if (taken && grp == isaPkg::grpCall) begin
            list.push_back(makeUop(0, 0, 1, 1, 0, 0, 0, microPkg::wrPcHigh, isaPkg::aluNop));
            list.push_back(makeUop(0, 0, 1, 1, 0, 0, 0, microPkg::wrPcLow, isaPkg::aluNop));
        end
        if (taken) begin
            list.push_back(makeUop(1, 0, 0, 0, 1, 0, 0, microPkg::wrNone, isaPkg::aluNop));
        end
    end
    return list;
endfunction

`endif

// File: testbench/decodeSliceTb.sv
// Testbench for the decode slice with a credit-returning queue model and a reference compare.
`default_nettype none

module decodeSliceTb;
    timeunit 1ns;
    timeprecision 1ps;

    `include "decodeRef.svh"

    localparam int randomOps = 160;

    logic clk;
    logic rst;
    logic opValid;
    isaPkg::opcode_t opcode;
    microPkg::flags_t flags;
    logic creditReturn;
    logic opReady;
    logic uopValid;
    logic uopLast;
    logic memRead;
    logic memWrite;
    logic spDec;
    logic pcLoad;
    logic writeA;
    logic writeFlags;
    microPkg::wrSel_t wrSel;
    isaPkg::aluOp_t aluOp;

    integer seed;
    uop_t expQ[$];
    isaPkg::opcode_t opList[$];
    microPkg::flags_t flagList[$];
    int dueQ[$];
    int totalUops;
    int uopCount;
    int lastCount;
    int acceptCount;
    int cycle;
    int cycleLimit;
    int modelCycle;
    int holdLeft;
    int tbCredits;

    decodeSlice UUT (
        .clk(clk),
        .rst(rst),
        .opValid(opValid),
        .opcode(opcode),
        .flags(flags),
        .creditReturn(creditReturn),
        .opReady(opReady),
        .uopValid(uopValid),
        .uopLast(uopLast),
        .memRead(memRead),
        .memWrite(memWrite),
        .spDec(spDec),
        .pcLoad(pcLoad),
        .writeA(writeA),
        .writeFlags(writeFlags),
        .wrSel(wrSel),
        .aluOp(aluOp)
    );

    always #20 clk = ~clk;

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("TB FAILED");
        $fatal(1, "run stopped on error");
    endtask

    task automatic checkBit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abortRun($sformatf("FAIL at %0t ns: %s is %b, expected %b", $time, name, got, exp));
        end
    endtask

    task automatic checkAluOp(input string name, input isaPkg::aluOp_t got,
                              input isaPkg::aluOp_t exp);
        if (got !== exp) begin
            abortRun($sformatf("FAIL at %0t ns: %s is %0h, expected %0h", $time, name, got, exp));
        end
    endtask

    task automatic checkWrSel(input string name, input microPkg::wrSel_t got,
                              input microPkg::wrSel_t exp);
        if (got !== exp) begin
            abortRun($sformatf("FAIL at %0t ns: %s is %0h, expected %0h", $time, name, got, exp));
        end
    endtask

    task automatic compareUop();
        uop_t e;
        e = expQ.pop_front();
        checkBit("uopLast", uopLast, e[posLast]);
        checkBit("memRead", memRead, e[posMemRead]);
        checkBit("memWrite", memWrite, e[posMemWrite]);
        checkBit("spDec", spDec, e[posSpDec]);
        checkBit("pcLoad", pcLoad, e[posPcLoad]);
        checkBit("writeA", writeA, e[posWriteA]);
        checkBit("writeFlags", writeFlags, e[posWriteFlags]);
        checkWrSel("wrSel", wrSel, microPkg::wrSel_t'(e[5:4]));
        checkAluOp("aluOp", aluOp, isaPkg::aluOp_t'(e[3:0]));
    endtask

    task automatic addOp(input isaPkg::opcode_t op, input microPkg::flags_t fl);
        uopList_t ops;
        ops = expandOp(op, fl);
        opList.push_back(op);
        flagList.push_back(fl);
        totalUops += ops.size();
    endtask

    task automatic sendOp(input isaPkg::opcode_t op, input microPkg::flags_t fl);
        @(negedge clk);
        opValid = 1'b1;
        opcode  = op;
        flags   = fl;
        @(posedge clk);
        while (!opReady) @(posedge clk);
        if ({$random(seed)} % 5 == 0) begin
            @(negedge clk);
            opValid = 1'b0; // an idle cycle with junk on the bus.
            opcode  = $random(seed);
        end
    endtask

    initial begin
        isaPkg::opcode_t op;
        microPkg::flags_t fl;
        clk = 1'b0;
        rst = 1'b1;
        opValid = 1'b0;
        opcode = '0;
        flags = '0;
        creditReturn = 1'b0;
        seed = 32'h634d8a8b;
        totalUops = 0;
        uopCount = 0;
        lastCount = 0;
        acceptCount = 0;
        cycle = 0;
        modelCycle = 0;
        holdLeft = 0;
        tbCredits = microPkg::creditInit;
        for (int i = 0; i < 8; i++) begin
            addOp({2'b11, 1'b0, 1'b0, 1'b1, 3'(i)}, microPkg::flags_t'($random(seed)));
            addOp({2'b11, 1'b1, 1'b1, 1'b1, 3'(i)}, microPkg::flags_t'($random(seed)));
        end
        // every condition, polarity and flag value for both branch groups.
        for (int k = 0; k < 16; k++) begin
            fl = microPkg::flags_t'($random(seed));
            fl[k / 4] = k[0];
            addOp({2'b01, 2'(k / 4), 1'b1, k[1], 2'b00}, fl);
            addOp({2'b10, 2'(k / 4), 1'b1, k[1], 2'b11}, fl);
        end
        for (int g = 0; g < 4; g++) begin
            op = $random(seed);
            op[7:6] = 2'(g);
            op[isaPkg::halfBit] = 1'b0;
            addOp(op, microPkg::flags_t'($random(seed)));
            op[7:6] = 2'b00;
            op[isaPkg::halfBit] = 1'b1;
            addOp(op, microPkg::flags_t'($random(seed)));
        end
        for (int i = 0; i < randomOps; i++) begin
            op = $random(seed);
            fl = microPkg::flags_t'($random(seed));
            addOp(op, fl);
        end
        cycleLimit = totalUops * 9 + 200;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        foreach (opList[i]) begin
            sendOp(opList[i], flagList[i]);
        end
        @(negedge clk);
        opValid = 1'b0;
        while (uopCount < totalUops) @(negedge clk);
        repeat (10) @(negedge clk); // a stray extra micro-op would show up here.
        if (expQ.size() != 0 || acceptCount != opList.size() || lastCount != acceptCount) begin
            abortRun($sformatf("counts disagree: %0d accepted of %0d, %0d last pulses, %0d left",
                               acceptCount, opList.size(), lastCount, expQ.size()));
        end else begin
            $display("TB PASSED");
            $finish;
        end
    end

    // the queue frees one entry per consumed credit, in order, after a random delay.
    always @(posedge clk) begin
        if (!rst) begin
            modelCycle = modelCycle + 1;
            if (uopValid) begin
                dueQ.push_back(modelCycle + {$random(seed)} % 8);
            end
        end
    end

    always @(negedge clk) begin
        creditReturn = 1'b0;
        if (!rst) begin
            if (holdLeft > 0) begin
                holdLeft--; // downstream is stalled and frees nothing.
            end else if ({$random(seed)} % 100 == 0) begin
                holdLeft = 16 + {$random(seed)} % 32;
            end else if (dueQ.size() > 0 && dueQ[0] <= modelCycle) begin
                creditReturn = 1'b1;
                void'(dueQ.pop_front());
            end
        end
    end

    always @(posedge clk) begin
        uopList_t ops;
        if (!rst) begin
            // a held instruction issues whenever a credit is left.
            checkBit("uopValid", uopValid, expQ.size() != 0 && tbCredits != 0);
            checkBit("opReady", opReady, expQ.size() == 0 || (uopValid && expQ[0][posLast]));
            if (uopValid) begin
                compareUop();
                uopCount++;
                if (uopLast) begin
                    lastCount++;
                end
            end
            if (opValid && opReady) begin
                ops = expandOp(opcode, flags);
                foreach (ops[i]) begin
                    expQ.push_back(ops[i]);
                end
                acceptCount++;
            end
            if (creditReturn) begin
                tbCredits++;
            end
            if (uopValid) begin
                tbCredits--;
            end
        end
    end

    always @(posedge clk) begin
        cycle++;
        if (cycle > cycleLimit) begin
            abortRun("micro-ops stopped issuing before the expected list was used up");
        end
    end

endmodule

`default_nettype wire
